/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path width
`define REG_SIZE 32

// Program counter width
`define ADDR_SIZE 32

// Register file index width, 32 registers
`define REG_ADDR 5

`endif

/* common/alu_pkg.sv */
package alu_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,  // Signed add, flags overflow
        ADDU = 4'd1,  // Add without overflow
        SUB  = 4'd2,  // Signed subtract, flags overflow
        SUBU = 4'd3,  // Also used for branch compare
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLT  = 4'd8,  // Signed less than
        SLTU = 4'd9,  // Unsigned less than
        SLL  = 4'd10, // Shift amount from operand 1
        SRL  = 4'd11, // Logical, zero fill
        LUI  = 4'd12  // Immediate into upper half
    } aluop_t;

    localparam logic [5:0] OP_RTYPE = 6'h00; // Operation in funct
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

/* common/pipe_pkg.sv */
`include "cpu_defs.svh"

package pipe_pkg;

    // Operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        FWD_REG = 2'd0, // Value read in decode
        FWD_MEM = 2'd1, // Result now in memory stage
        FWD_WB  = 2'd2  // Value being written back
    } fwd_sel_t;

    // Decode to execute
    typedef struct packed {
        logic [5:0]            opcode;
        logic [5:0]            funct;
        logic [`REG_ADDR-1:0]  rs;         // Source for operand 1
        logic [`REG_ADDR-1:0]  rt;         // Source for operand 2 and store data
        logic [`REG_ADDR-1:0]  dst_reg;
        logic [`REG_SIZE-1:0]  reg1_data;  // Register file read of rs
        logic [`REG_SIZE-1:0]  reg2_data;  // Register file read of rt
        logic [`REG_SIZE-1:0]  imm;        // Already sign or zero extended
        logic [`ADDR_SIZE-1:0] old_pc;
        logic                  alusrc_imm; // Operand 2 is imm
        logic                  regwrite;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_byte;
        logic                  memtoreg;   // Writeback takes load data
        logic                  is_branch;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic [`REG_SIZE-1:0]  alu_result;
        logic [`REG_SIZE-1:0]  data_store; // Forwarded rt value
        logic [`ADDR_SIZE-1:0] pc_branch;  // Taken branch target
        logic                  zero;
        logic                  overflow;   // Reported only
        logic [`REG_ADDR-1:0]  dst_reg;
        logic                  regwrite;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_byte;
        logic                  memtoreg;
        logic                  is_branch;
    } ex_mem_t;

    // Writeback value seen by the forwarding path
    typedef struct packed {
        logic                 regwrite;
        logic [`REG_ADDR-1:0] dst_reg;
        logic [`REG_SIZE-1:0] data;
    } wb_fwd_t;

endpackage

/* logic/alu_decoder.sv */
module alu_decoder
    import alu_pkg::*;
(
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output aluop_t     aluop
);

    always_comb begin
        aluop = ADDU; // Fallback for unknown codes
        case (opcode)
            OP_RTYPE: begin
                case (funct) // R-type takes op from funct
                    FN_ADD:  aluop = ADD;
                    FN_ADDU: aluop = ADDU;
                    FN_SUB:  aluop = SUB;
                    FN_SUBU: aluop = SUBU;
                    FN_AND:  aluop = AND;
                    FN_OR:   aluop = OR;
                    FN_XOR:  aluop = XOR;
                    FN_NOR:  aluop = NOR;
                    FN_SLT:  aluop = SLT;
                    FN_SLTU: aluop = SLTU;
                    FN_SLL:  aluop = SLL;
                    FN_SRL:  aluop = SRL;
                    default: aluop = ADDU;
                endcase
            end
            OP_ADDI:  aluop = ADD;  // Trapping add
            OP_ADDIU: aluop = ADDU;
            OP_SLTI:  aluop = SLT;
            OP_ANDI:  aluop = AND;
            OP_ORI:   aluop = OR;
            OP_XORI:  aluop = XOR;
            OP_LUI:   aluop = LUI;
            OP_LW,
            OP_SW:    aluop = ADDU; // Base plus offset
            OP_BEQ,
            OP_BNE:   aluop = SUBU; // Compare through zero flag
            default:  aluop = ADDU;
        endcase
    end

endmodule

/* logic/alu.sv */
`include "cpu_defs.svh"

module alu
    import alu_pkg::*;
(
    input  aluop_t               aluop,
    input  logic [`REG_SIZE-1:0] src1,
    input  logic [`REG_SIZE-1:0] src2,
    output logic [`REG_SIZE-1:0] result,
    output logic                 zero,
    output logic                 overflow
);

    localparam int MSB = `REG_SIZE - 1;

    logic [`REG_SIZE-1:0] sum;     // Shared by ADD and ADDU
    logic [`REG_SIZE-1:0] diff;    // Shared by SUB, SUBU and branches
    logic                 add_ovf; // Signed overflow of sum
    logic                 sub_ovf; // Signed overflow of diff
    logic                 lt_s;
    logic                 lt_u;
    logic [4:0]           shamt;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0]; // Only low five bits count

    // Same signs in, different sign out
    assign add_ovf = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
    // Opposite signs in, result sign flips from src1
    assign sub_ovf = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);

    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    always_comb begin
        result = sum;
        case (aluop)
            ADD, ADDU: result = sum;
            SUB, SUBU: result = diff;
            AND:       result = src1 & src2;
            OR:        result = src1 | src2;
            XOR:       result = src1 ^ src2;
            NOR:       result = ~(src1 | src2);
            SLT:       result = {{(`REG_SIZE-1){1'b0}}, lt_s};
            SLTU:      result = {{(`REG_SIZE-1){1'b0}}, lt_u};
            SLL:       result = src2 << shamt;
            SRL:       result = src2 >> shamt; // Logical shift
            LUI:       result = {src2[15:0], 16'h0000};
            default:   result = sum;
        endcase
    end

    assign zero = (result == '0);

    // Only the trapping forms report overflow
    assign overflow = ((aluop == ADD) && add_ovf) || ((aluop == SUB) && sub_ovf);

endmodule

/* logic/forward_unit.sv */
`include "cpu_defs.svh"

module forward_unit
    import pipe_pkg::*;
(
    input  logic [`REG_ADDR-1:0] rs,
    input  logic [`REG_ADDR-1:0] rt,
    input  ex_mem_t              ex_mem,
    input  wb_fwd_t              wb_fwd,
    output fwd_sel_t             fwd_src1,
    output fwd_sel_t             fwd_src2
);

    // Writer targets this source; r0 is hardwired so never matches
    function automatic logic hit(
        input logic                 we,
        input logic [`REG_ADDR-1:0] dst,
        input logic [`REG_ADDR-1:0] src
    );
        return we && (dst != '0) && (dst == src);
    endfunction

    logic mem_hit1; // Memory stage writes rs
    logic mem_hit2; // Memory stage writes rt
    logic wb_hit1;
    logic wb_hit2;

    assign mem_hit1 = hit(ex_mem.regwrite, ex_mem.dst_reg, rs);
    assign mem_hit2 = hit(ex_mem.regwrite, ex_mem.dst_reg, rt);
    assign wb_hit1  = hit(wb_fwd.regwrite, wb_fwd.dst_reg, rs);
    assign wb_hit2  = hit(wb_fwd.regwrite, wb_fwd.dst_reg, rt);

    // Newer value from memory wins over writeback
    always_comb begin
        fwd_src1 = mem_hit1 ? FWD_MEM : (wb_hit1 ? FWD_WB : FWD_REG);
        fwd_src2 = mem_hit2 ? FWD_MEM : (wb_hit2 ? FWD_WB : FWD_REG);
    end

endmodule

/* execute/exec_stage.sv */
`include "cpu_defs.svh"

module exec_stage
    import alu_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance, // Stage enable, low while stalled
    input  id_ex_t               id_ex,
    input  fwd_sel_t             fwd_src1,
    input  fwd_sel_t             fwd_src2,
    input  logic [`REG_SIZE-1:0] wb_data, // Value being written back
    output ex_mem_t              ex_mem
);

    aluop_t               aluop;
    logic [`REG_SIZE-1:0] rs_val;     // Forwarded rs
    logic [`REG_SIZE-1:0] rt_val;     // Forwarded rt
    logic [`REG_SIZE-1:0] operand2;
    logic [`REG_SIZE-1:0] alu_out;
    logic                 alu_zero;
    logic                 alu_ovf;
    logic [`ADDR_SIZE-1:0] target;
    ex_mem_t              ex_mem_next;

    // Forward muxes, memory value is our own registered result
    always_comb begin
        case (fwd_src1)
            FWD_MEM: rs_val = ex_mem.alu_result;
            FWD_WB:  rs_val = wb_data;
            default: rs_val = id_ex.reg1_data;
        endcase
        case (fwd_src2)
            FWD_MEM: rt_val = ex_mem.alu_result;
            FWD_WB:  rt_val = wb_data;
            default: rt_val = id_ex.reg2_data;
        endcase
    end

    assign operand2 = id_ex.alusrc_imm ? id_ex.imm : rt_val;

    // Word offset to byte offset
    assign target = id_ex.old_pc + {id_ex.imm[`ADDR_SIZE-3:0], 2'b00};

    alu_decoder u_alu_decoder (
        .opcode (id_ex.opcode),
        .funct  (id_ex.funct),
        .aluop  (aluop)
    );

    alu u_alu (
        .aluop    (aluop),
        .src1     (rs_val),
        .src2     (operand2),
        .result   (alu_out),
        .zero     (alu_zero),
        .overflow (alu_ovf)
    );

    always_comb begin
        ex_mem_next.alu_result = alu_out;
        ex_mem_next.data_store = rt_val; // Not operand2, stores use imm there
        ex_mem_next.pc_branch  = target;
        ex_mem_next.zero       = alu_zero;
        ex_mem_next.overflow   = alu_ovf;
        ex_mem_next.dst_reg    = id_ex.dst_reg;
        ex_mem_next.regwrite   = id_ex.regwrite;
        ex_mem_next.mem_read   = id_ex.mem_read;
        ex_mem_next.mem_write  = id_ex.mem_write;
        ex_mem_next.is_byte    = id_ex.is_byte;
        ex_mem_next.memtoreg   = id_ex.memtoreg;
        ex_mem_next.is_branch  = id_ex.is_branch;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;           // Bubble, all controls inactive
        end else if (advance) begin
            ex_mem <= ex_mem_next;
        end                         // Otherwise hold during stall
    end

endmodule

/* execute/execute_top.sv */
module execute_top
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    advance, // From hazard logic
    input  id_ex_t  id_ex,
    input  wb_fwd_t wb_fwd,
    output ex_mem_t ex_mem
);

    fwd_sel_t fwd_src1;
    fwd_sel_t fwd_src2;

    // Compares against the instruction now sitting in memory stage
    forward_unit u_forward_unit (
        .rs       (id_ex.rs),
        .rt       (id_ex.rt),
        .ex_mem   (ex_mem),
        .wb_fwd   (wb_fwd),
        .fwd_src1 (fwd_src1),
        .fwd_src2 (fwd_src2)
    );

    exec_stage u_exec_stage (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .id_ex    (id_ex),
        .fwd_src1 (fwd_src1),
        .fwd_src2 (fwd_src2),
        .wb_data  (wb_fwd.data),
        .ex_mem   (ex_mem)
    );

endmodule

/* tests/execute_tb.sv */
`include "cpu_defs.svh"

module execute_tb
    import alu_pkg::*;
    import pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic    clk = 1'b0;
    logic    reset;
    logic    advance;
    id_ex_t  id_ex;
    wb_fwd_t wb_fwd;
    ex_mem_t ex_mem;

    ex_mem_t exp_mem = '0;  // Model of ex_mem
    ex_mem_t prev_mem = '0; // Model of the bundle now in writeback
    ex_mem_t pending;       // Expected capture at the next advancing edge
    integer  seed = 32'hd94e_0ed4;
    int      cycles_checked = 0;
    int      check_errors = 0;
    int      flow_errors = 0;

    logic [5:0] functs [13] = '{FN_SLL, FN_SRL, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                                FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, 6'h3f};
    logic [5:0] opcodes [12] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI,
                                 OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE, 6'h3e};

    execute_top UUT (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .id_ex   (id_ex),
        .wb_fwd  (wb_fwd),
        .ex_mem  (ex_mem)
    );

    initial begin
        forever #10 clk = ~clk; // 20 ns period
    end

    // Pipeline model moves only on advancing edges
    always @(posedge clk) begin
        if (reset) begin
            exp_mem  <= '0;
            prev_mem <= '0;
        end else if (advance) begin
            prev_mem <= exp_mem;
            exp_mem  <= pending;
        end
    end

    always @(negedge clk) begin
        cycles_checked++;
    end

    // Sampled on the falling edge half a cycle after each capture
    ex_mem_match: assert property (@(negedge clk) ex_mem === exp_mem)
        else begin
            check_errors++;
            report_fields();
        end

    function automatic logic [`REG_SIZE-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic imm_operand(input logic [5:0] opcode);
        return !(opcode inside {OP_RTYPE, OP_BEQ, OP_BNE}); // Branches compare two registers
    endfunction

    function automatic aluop_t decode_ref(input logic [5:0] opcode, input logic [5:0] funct);
        if (opcode == OP_RTYPE) begin
            case (funct)
                FN_ADD:  return ADD;
                FN_SUB:  return SUB;
                FN_SUBU: return SUBU;
                FN_AND:  return AND;
                FN_OR:   return OR;
                FN_XOR:  return XOR;
                FN_NOR:  return NOR;
                FN_SLT:  return SLT;
                FN_SLTU: return SLTU;
                FN_SLL:  return SLL;
                FN_SRL:  return SRL;
                default: return ADDU; // FN_ADDU and unknown
            endcase
        end
        case (opcode)
            OP_ADDI:        return ADD;
            OP_SLTI:        return SLT;
            OP_ANDI:        return AND;
            OP_ORI:         return OR;
            OP_XORI:        return XOR;
            OP_LUI:         return LUI;
            OP_BEQ, OP_BNE: return SUBU;
            default:        return ADDU; // ADDIU, LW, SW and unknown
        endcase
    endfunction

    // Overflow when the 64-bit result does not fit back into 32 bits
    function automatic void alu_ref(input aluop_t op, input logic [`REG_SIZE-1:0] a,
                                    input logic [`REG_SIZE-1:0] b,
                                    output logic [`REG_SIZE-1:0] r, output logic v);
        longint sa;
        longint sb;
        longint wide;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        wide = 0;
        v = 1'b0;
        case (op)
            ADD, ADDU: wide = sa + sb;
            SUB, SUBU: wide = sa - sb;
            default:   wide = 0;
        endcase
        case (op)
            ADD, ADDU, SUB, SUBU: r = wide[`REG_SIZE-1:0];
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            NOR:     r = ~(a | b);
            SLT:     r = (sa < sb) ? 32'd1 : 32'd0;
            SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            SLL:     r = b << a[4:0];
            SRL:     r = b >> a[4:0];
            LUI:     r = {b[15:0], 16'h0000};
            default: r = 32'd0;
        endcase
        if (op == ADD || op == SUB) begin
            v = (wide != longint'($signed(r)));
        end
    endfunction

    // Memory before writeback and r0 never forwarded
    function automatic logic [`REG_SIZE-1:0] source_value(input logic [4:0] idx,
                                                          input logic [`REG_SIZE-1:0] reg_val,
                                                          input ex_mem_t mem, input wb_fwd_t wb);
        if (idx != 5'd0 && mem.regwrite && mem.dst_reg == idx) begin
            return mem.alu_result;
        end
        if (idx != 5'd0 && wb.regwrite && wb.dst_reg == idx) begin
            return wb.data;
        end
        return reg_val;
    endfunction

    function automatic ex_mem_t predict(input id_ex_t d, input ex_mem_t mem, input wb_fwd_t wb);
        ex_mem_t              e;
        logic [`REG_SIZE-1:0] a;
        logic [`REG_SIZE-1:0] rt_v;
        logic [`REG_SIZE-1:0] r;
        logic                 v;
        e = '0;
        a = source_value(d.rs, d.reg1_data, mem, wb);
        rt_v = source_value(d.rt, d.reg2_data, mem, wb);
        alu_ref(decode_ref(d.opcode, d.funct), a, d.alusrc_imm ? d.imm : rt_v, r, v);
        e.alu_result = r;
        e.overflow   = v;
        e.zero       = (r == 32'd0);
        e.data_store = rt_v;                  // Store data skips the imm mux
        e.pc_branch  = d.old_pc + d.imm * 4;  // Word offset
        e.dst_reg    = d.dst_reg;
        e.regwrite   = d.regwrite;
        e.mem_read   = d.mem_read;
        e.mem_write  = d.mem_write;
        e.is_byte    = d.is_byte;
        e.memtoreg   = d.memtoreg;
        e.is_branch  = d.is_branch;
        return e;
    endfunction

    function automatic id_ex_t random_instr();
        id_ex_t               i;
        logic [`REG_SIZE-1:0] r;
        logic [`REG_SIZE-1:0] w;
        r = rand_word();
        w = rand_word();
        i = '0;
        i.opcode     = r[0] ? OP_RTYPE : opcodes[int'(r[31:28]) % 12];
        i.funct      = functs[int'(r[7:4]) % 13];
        i.rs         = {2'b00, r[10:8]};  // Few registers give many hazards
        i.rt         = {2'b00, r[13:11]};
        i.dst_reg    = {2'b00, r[16:14]}; // r0 included
        i.reg1_data  = rand_word();
        i.reg2_data  = (r[3:1] == 3'd0) ? i.reg1_data : rand_word(); // Equal operands now and then
        i.imm        = r[17] ? w : {{16{w[15]}}, w[15:0]};
        i.old_pc     = rand_word();
        i.alusrc_imm = imm_operand(i.opcode);
        i.regwrite   = r[19];
        i.mem_read   = r[20];
        i.mem_write  = r[21];
        i.is_byte    = r[22];
        i.memtoreg   = r[23];
        i.is_branch  = r[24];
        return i;
    endfunction

    task automatic compare_field(input string name, input logic [`REG_SIZE-1:0] got,
                                 input logic [`REG_SIZE-1:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_fields();
        compare_field("alu_result", ex_mem.alu_result, exp_mem.alu_result);
        compare_field("data_store", ex_mem.data_store, exp_mem.data_store);
        compare_field("pc_branch", ex_mem.pc_branch, exp_mem.pc_branch);
        compare_field("zero", 32'(ex_mem.zero), 32'(exp_mem.zero));
        compare_field("overflow", 32'(ex_mem.overflow), 32'(exp_mem.overflow));
        compare_field("dst_reg", 32'(ex_mem.dst_reg), 32'(exp_mem.dst_reg));
        compare_field("regwrite", 32'(ex_mem.regwrite), 32'(exp_mem.regwrite));
        compare_field("mem_read", 32'(ex_mem.mem_read), 32'(exp_mem.mem_read));
        compare_field("mem_write", 32'(ex_mem.mem_write), 32'(exp_mem.mem_write));
        compare_field("is_byte", 32'(ex_mem.is_byte), 32'(exp_mem.is_byte));
        compare_field("memtoreg", 32'(ex_mem.memtoreg), 32'(exp_mem.memtoreg));
        compare_field("is_branch", 32'(ex_mem.is_branch), 32'(exp_mem.is_branch));
    endtask

    // Drives on the falling edge and mirrors the model into writeback
    task automatic issue(input id_ex_t instr, input logic adv);
        @(negedge clk);
        id_ex           = instr;
        advance         = adv;
        wb_fwd.regwrite = prev_mem.regwrite;
        wb_fwd.dst_reg  = prev_mem.dst_reg;
        wb_fwd.data     = prev_mem.alu_result; // ALU result stands in for load data
        pending         = predict(instr, exp_mem, wb_fwd);
    endtask

    task automatic flush();
        id_ex_t nop;
        nop = '0;
        repeat (2) issue(nop, 1'b1); // Clears memory and writeback hazards
    endtask

    task automatic decoded_op_cases();
        id_ex_t i;
        for (int k = 0; k < 13; k++) begin
            repeat (3) begin
                i = random_instr();
                i.opcode = OP_RTYPE;
                i.funct = functs[k];
                i.alusrc_imm = 1'b0;
                issue(i, 1'b1);
            end
        end
        for (int k = 0; k < 12; k++) begin
            repeat (3) begin
                i = random_instr();
                i.opcode = opcodes[k];
                i.alusrc_imm = imm_operand(opcodes[k]);
                issue(i, 1'b1);
            end
        end
    endtask

    task automatic flag_cases();
        id_ex_t i;
        flush();
        i = '0;
        i.rs = 5'd1;
        i.rt = 5'd2;
        i.reg1_data = 32'h7fff_ffff;
        i.reg2_data = 32'h0000_0001;
        i.funct = FN_ADD;
        issue(i, 1'b1);             // Positive wrap
        i.funct = FN_ADDU;
        issue(i, 1'b1);
        i.reg1_data = 32'h8000_0000;
        i.funct = FN_SUB;
        issue(i, 1'b1);             // Negative wrap
        i.funct = FN_SUBU;
        issue(i, 1'b1);
        i.reg2_data = 32'h8000_0000;
        i.funct = FN_ADD;
        issue(i, 1'b1);             // Two minimums
        i.funct = FN_SUBU;
        issue(i, 1'b1);             // Equal operands give zero
        i.opcode = OP_ADDI;
        i.alusrc_imm = 1'b1;
        i.imm = 32'h0000_0001;
        i.reg1_data = 32'h7fff_ffff;
        issue(i, 1'b1);
        i.opcode = OP_ADDIU;
        issue(i, 1'b1);
    endtask

    task automatic forwarding_cases();
        id_ex_t p;
        id_ex_t c;
        flush();
        p = '0;
        p.funct = FN_ADDU;
        p.rs = 5'd1;
        p.reg1_data = 32'h0000_1111;
        p.regwrite = 1'b1;
        p.dst_reg = 5'd5;
        issue(p, 1'b1);
        c = p;
        c.rs = 5'd5;
        c.reg1_data = 32'hdead_beef; // Stale value, memory result expected
        c.dst_reg = 5'd6;
        issue(c, 1'b1);
        c = '0;
        c.funct = FN_OR;
        c.rs = 5'd5;                 // r5 now in writeback
        c.rt = 5'd3;
        c.regwrite = 1'b1;
        c.dst_reg = 5'd0;
        issue(c, 1'b1);
        c = '0;
        c.reg1_data = 32'd7;
        c.reg2_data = 32'd9;
        c.funct = FN_ADDU;           // Reads r0 behind an r0 writer
        issue(c, 1'b1);
        p.rs = 5'd1;
        p.reg1_data = 32'd100;
        p.dst_reg = 5'd7;
        issue(p, 1'b1);
        p.reg1_data = 32'd200;
        issue(p, 1'b1);
        c.rs = 5'd7;                 // r7 in both stages
        c.rt = 5'd7;
        issue(c, 1'b1);
        p.reg1_data = 32'h5a5a_0000;
        p.dst_reg = 5'd9;
        issue(p, 1'b1);
        c = '0;
        c.opcode = OP_SW;
        c.rs = 5'd1;
        c.rt = 5'd9;
        c.reg2_data = 32'h0000_0bad;
        c.alusrc_imm = 1'b1;
        c.imm = 32'h0000_0010;
        c.mem_write = 1'b1;
        issue(c, 1'b1);
    endtask

    task automatic branch_cases();
        id_ex_t i;
        i = '0;
        i.opcode = OP_BEQ;
        i.is_branch = 1'b1;
        i.rs = 5'd3;
        i.rt = 5'd4;
        i.reg1_data = 32'd42;
        i.reg2_data = 32'd42;
        i.old_pc = 32'h0000_1000;
        i.imm = 32'hffff_fffc;       // Four words back
        issue(i, 1'b1);
        i.opcode = OP_BNE;
        i.reg2_data = 32'd41;
        i.imm = 32'h0000_0040;
        issue(i, 1'b1);
        i.old_pc = 32'h0000_0008;
        i.imm = 32'hffff_fff0;       // Target below address zero
        issue(i, 1'b1);
    endtask

    task automatic stall_case(output logic ok);
        id_ex_t  i;
        ex_mem_t held;
        ex_mem_t target_mem;
        int      cycles;
        issue(random_instr(), 1'b1);
        i = random_instr();
        issue(i, 1'b0);
        held = exp_mem;
        repeat (4) begin
            issue(i, 1'b0);          // Same bundle while stalled
            assert (ex_mem === held) else begin
                flow_errors++;
                $display("CHECK FAILED t=%0t ex_mem: got %h expected %h", $time, ex_mem, held);
            end
        end
        target_mem = pending;
        issue(i, 1'b1);
        cycles = 0;
        do begin
            @(negedge clk);
            advance = 1'b0;
            cycles++;
        end while (ex_mem !== target_mem && cycles < 8);
        if (ex_mem !== target_mem) begin
            flow_errors++;
            $display("Held instruction did not reach ex_mem within %0d cycles", cycles);
            ok = 1'b0;
        end else begin
            ok = 1'b1;
            assert (cycles == 1) else begin
                flow_errors++;
                $display("CHECK FAILED t=%0t latency: got %0d expected 1", $time, cycles);
            end
        end
    endtask

    task automatic reset_case();
        @(negedge clk);
        reset = 1'b1;
        advance = 1'b1;
        id_ex = random_instr();      // Ignored while in reset
        repeat (3) @(negedge clk);
        reset = 1'b0;
        advance = 1'b0;
        repeat (20) issue(random_instr(), 1'b1);
    endtask

    task automatic end_run();
        $display("Checked %0d cycles, %0d bundle errors, %0d other errors",
                 cycles_checked, check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        reset = 1'b1;
        advance = 1'b0;
        id_ex = '0;
        wb_fwd = '0;
        pending = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        decoded_op_cases();
        flag_cases();
        forwarding_cases();
        branch_cases();
        repeat (300) issue(random_instr(), 1'b1);
        stall_case(ok);
        if (ok) begin
            reset_case();
        end
        end_run();
    end

endmodule

/* filelist.f */
+incdir+common
common/alu_pkg.sv
common/pipe_pkg.sv
logic/alu_decoder.sv
logic/alu.sv
logic/forward_unit.sv
execute/exec_stage.sv
execute/execute_top.sv
tests/execute_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module execute_tb -Mdir obj_dir

output=$(./obj_dir/Vexecute_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
